/* gp_axi_bridge.f */
src/axi_bridge_pkg.sv
src/reset_stretch.sv
src/burst_write_splitter.sv
src/burst_read_splitter.sv
src/lite_skid_buffer.sv
src/lite_reg_file.sv
src/gp_axi_bridge.sv
test/tb_gp_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_gp_axi_bridge \
    -f gp_axi_bridge.f -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "^Testbench passed$" sim.log && echo "simulation ok, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* src/axi_bridge_pkg.sv */
`default_nettype none

package axi_bridge_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [11:0] id_t;
    typedef logic [3:0]  len_t;    // beats minus one.
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  reg_idx_t;

    localparam resp_t  RESP_OKAY   = 2'b00;
    localparam resp_t  RESP_SLVERR = 2'b10;
    localparam burst_t BURST_FIXED = 2'b00;

    // sixteen words cover byte addresses 0x00 to 0x3C.
    localparam int REG_COUNT = 16;

    // a write request is packed as {addr, data, strb}.
    localparam int WREQ_W = $bits(addr_t) + $bits(data_t) + $bits(strb_t);
    localparam int RREQ_W = $bits(addr_t);

    localparam int RESET_HOLD = 8;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BEATS,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_BEATS
    } rd_state_t;

endpackage

`default_nettype wire

/* src/burst_read_splitter.sv */
`default_nettype none

module burst_read_splitter (
    input  logic                              clock,
    input  logic                              rst_n,

    input  axi_bridge_pkg::id_t               arid,
    input  axi_bridge_pkg::addr_t             araddr,
    input  axi_bridge_pkg::len_t              arlen,
    input  axi_bridge_pkg::burst_t            arburst,
    input  logic                              arvalid,
    output logic                              arready,

    output axi_bridge_pkg::id_t               rid,
    output axi_bridge_pkg::data_t             rdata,
    output axi_bridge_pkg::resp_t             rresp,
    output logic                              rlast,
    output logic                              rvalid,
    input  logic                              rready,

    output logic                              rreq_valid,
    input  logic                              rreq_ready,
    output logic [axi_bridge_pkg::RREQ_W-1:0] rreq_data,

    input  logic                              rrsp_valid,
    output logic                              rrsp_ready,
    input  axi_bridge_pkg::data_t             rrsp_data,
    input  axi_bridge_pkg::resp_t             rrsp_resp
);

    axi_bridge_pkg::rd_state_t state;
    axi_bridge_pkg::addr_t     beat_addr;
    axi_bridge_pkg::len_t      len_q;
    axi_bridge_pkg::len_t      ret_cnt;
    logic                      fixed_q;
    logic [4:0]                issue_cnt;
    logic [4:0]                issue_total;

    assign issue_total = {1'b0, len_q} + 5'd1;

    // requests run ahead of the returns, up to what the buffer will take.
    assign rreq_valid = (state == axi_bridge_pkg::RD_BEATS) && (issue_cnt != issue_total);
    assign rreq_data  = beat_addr;

    // lite responses go straight out as R beats.
    assign rvalid     = (state == axi_bridge_pkg::RD_BEATS) && rrsp_valid;
    assign rrsp_ready = (state == axi_bridge_pkg::RD_BEATS) && rready;
    assign rdata      = rrsp_data;
    assign rresp      = rrsp_resp;
    assign rlast      = (ret_cnt == len_q);

    // ######################################
    // burst control
    // ######################################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= axi_bridge_pkg::RD_IDLE;
            arready   <= 1'b0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            case (state)
                axi_bridge_pkg::RD_IDLE: begin
                    arready <= 1'b1;
                    if (arvalid && arready) begin
                        state     <= axi_bridge_pkg::RD_BEATS;
                        arready   <= 1'b0;
                        issue_cnt <= '0;
                        ret_cnt   <= '0;
                    end
                end
                axi_bridge_pkg::RD_BEATS: begin
                    if (rreq_valid && rreq_ready) begin
                        issue_cnt <= issue_cnt + 5'd1;
                    end
                    if (rvalid && rready) begin
                        if (rlast) begin
                            state   <= axi_bridge_pkg::RD_IDLE;
                            arready <= 1'b1;
                        end else begin
                            ret_cnt <= ret_cnt + 4'd1;
                        end
                    end
                end
                default: state <= axi_bridge_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rid       <= arid;
            beat_addr <= araddr;
            len_q     <= arlen;
            fixed_q   <= (arburst == axi_bridge_pkg::BURST_FIXED);
        end else if (rreq_valid && rreq_ready && !fixed_q) begin
            beat_addr <= beat_addr + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* src/burst_write_splitter.sv */
`default_nettype none

module burst_write_splitter (
    input  logic                              clock,
    input  logic                              rst_n,

    input  axi_bridge_pkg::id_t               awid,
    input  axi_bridge_pkg::addr_t             awaddr,
    input  axi_bridge_pkg::len_t              awlen,
    input  axi_bridge_pkg::burst_t            awburst,
    input  logic                              awvalid,
    output logic                              awready,

    input  axi_bridge_pkg::data_t             wdata,
    input  axi_bridge_pkg::strb_t             wstrb,
    input  logic                              wvalid,
    output logic                              wready,

    output axi_bridge_pkg::id_t               bid,
    output axi_bridge_pkg::resp_t             bresp,
    output logic                              bvalid,
    input  logic                              bready,

    output logic                              wreq_valid,
    input  logic                              wreq_ready,
    output logic [axi_bridge_pkg::WREQ_W-1:0] wreq_data,

    input  logic                              wrsp_valid,
    output logic                              wrsp_ready,
    input  axi_bridge_pkg::resp_t             wrsp_resp
);

    axi_bridge_pkg::wr_state_t state;
    axi_bridge_pkg::addr_t     beat_addr;
    axi_bridge_pkg::len_t      len_q;
    logic                      fixed_q;
    logic [4:0]                sent_cnt;
    logic [4:0]                rcvd_cnt;
    logic [4:0]                beat_total;
    logic                      all_sent;

    assign beat_total = {1'b0, len_q} + 5'd1;
    assign all_sent   = (sent_cnt == beat_total);

    // each accepted W beat becomes one lite request in the same cycle.
    assign wreq_valid = (state == axi_bridge_pkg::WR_BEATS) && wvalid && !all_sent;
    assign wready     = (state == axi_bridge_pkg::WR_BEATS) && wreq_ready && !all_sent;
    assign wreq_data  = {beat_addr, wdata, wstrb};
    assign wrsp_ready = (state == axi_bridge_pkg::WR_BEATS);
    assign bvalid     = (state == axi_bridge_pkg::WR_RESP);

    // ######################################
    // burst control
    // ######################################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= axi_bridge_pkg::WR_IDLE;
            awready  <= 1'b0;
            sent_cnt <= '0;
            rcvd_cnt <= '0;
        end else begin
            case (state)
                axi_bridge_pkg::WR_IDLE: begin
                    awready <= 1'b1;
                    if (awvalid && awready) begin
                        state    <= axi_bridge_pkg::WR_BEATS;
                        awready  <= 1'b0;
                        sent_cnt <= '0;
                        rcvd_cnt <= '0;
                    end
                end
                axi_bridge_pkg::WR_BEATS: begin
                    if (wreq_valid && wreq_ready) begin
                        sent_cnt <= sent_cnt + 5'd1;
                    end
                    // awlen fixes the count, so wlast is never consulted.
                    if (wrsp_valid && wrsp_ready) begin
                        rcvd_cnt <= rcvd_cnt + 5'd1;
                        if (rcvd_cnt + 5'd1 == beat_total) begin
                            state <= axi_bridge_pkg::WR_RESP;
                        end
                    end
                end
                axi_bridge_pkg::WR_RESP: begin
                    if (bready) begin
                        state   <= axi_bridge_pkg::WR_IDLE;
                        awready <= 1'b1;
                    end
                end
                default: state <= axi_bridge_pkg::WR_IDLE;
            endcase
        end
    end

    // ######################################
    // captured burst and merged response
    // ######################################

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            bid       <= awid;
            beat_addr <= awaddr;
            len_q     <= awlen;
            fixed_q   <= (awburst == axi_bridge_pkg::BURST_FIXED);
            bresp     <= axi_bridge_pkg::RESP_OKAY;
        end else begin
            if (wreq_valid && wreq_ready && !fixed_q) begin
                beat_addr <= beat_addr + 32'd4;   // WRAP is handled as INCR.
            end
            if (wrsp_valid && wrsp_ready && wrsp_resp == axi_bridge_pkg::RESP_SLVERR) begin
                bresp <= axi_bridge_pkg::RESP_SLVERR;   // one bad beat fails the burst.
            end
        end
    end

endmodule

`default_nettype wire

/* src/gp_axi_bridge.sv */
`default_nettype none

module gp_axi_bridge (
    input  logic                   clock,
    input  logic                   rst_n,

    input  axi_bridge_pkg::id_t    awid,
    input  axi_bridge_pkg::addr_t  awaddr,
    input  axi_bridge_pkg::len_t   awlen,
    input  axi_bridge_pkg::burst_t awburst,
    input  logic                   awvalid,
    output logic                   awready,

    input  axi_bridge_pkg::data_t  wdata,
    input  axi_bridge_pkg::strb_t  wstrb,
    input  logic                   wlast,    // implied by awlen, one burst at a time.
    input  logic                   wvalid,
    output logic                   wready,

    output axi_bridge_pkg::id_t    bid,
    output axi_bridge_pkg::resp_t  bresp,
    output logic                   bvalid,
    input  logic                   bready,

    input  axi_bridge_pkg::id_t    arid,
    input  axi_bridge_pkg::addr_t  araddr,
    input  axi_bridge_pkg::len_t   arlen,
    input  axi_bridge_pkg::burst_t arburst,
    input  logic                   arvalid,
    output logic                   arready,

    output axi_bridge_pkg::id_t    rid,
    output axi_bridge_pkg::data_t  rdata,
    output axi_bridge_pkg::resp_t  rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready
);

    logic                              periph_rst_n;

    logic                              wreq_valid;
    logic                              wreq_ready;
    logic [axi_bridge_pkg::WREQ_W-1:0] wreq_data;
    logic                              wbuf_valid;
    logic                              wbuf_ready;
    logic [axi_bridge_pkg::WREQ_W-1:0] wbuf_data;
    logic                              wrsp_valid;
    logic                              wrsp_ready;
    axi_bridge_pkg::resp_t             wrsp_resp;

    logic                              rreq_valid;
    logic                              rreq_ready;
    logic [axi_bridge_pkg::RREQ_W-1:0] rreq_data;
    logic                              rbuf_valid;
    logic                              rbuf_ready;
    logic [axi_bridge_pkg::RREQ_W-1:0] rbuf_data;
    logic                              rrsp_valid;
    logic                              rrsp_ready;
    axi_bridge_pkg::data_t             rrsp_data;
    axi_bridge_pkg::resp_t             rrsp_resp;

    reset_stretch rst_i (
        .clock, .rst_n, .periph_rst_n
    );

    burst_write_splitter wr_split (
        .clock, .rst_n(periph_rst_n),
        .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .wreq_valid, .wreq_ready, .wreq_data,
        .wrsp_valid, .wrsp_ready, .wrsp_resp
    );

    burst_read_splitter rd_split (
        .clock, .rst_n(periph_rst_n),
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .rreq_valid, .rreq_ready, .rreq_data,
        .rrsp_valid, .rrsp_ready, .rrsp_data, .rrsp_resp
    );

    lite_skid_buffer #(.WIDTH(axi_bridge_pkg::WREQ_W)) wr_buf (
        .clock, .rst_n(periph_rst_n),
        .in_valid(wreq_valid), .in_ready(wreq_ready), .in_data(wreq_data),
        .out_valid(wbuf_valid), .out_ready(wbuf_ready), .out_data(wbuf_data)
    );

    lite_skid_buffer #(.WIDTH(axi_bridge_pkg::RREQ_W)) rd_buf (
        .clock, .rst_n(periph_rst_n),
        .in_valid(rreq_valid), .in_ready(rreq_ready), .in_data(rreq_data),
        .out_valid(rbuf_valid), .out_ready(rbuf_ready), .out_data(rbuf_data)
    );

    lite_reg_file regs_i (
        .clock, .rst_n(periph_rst_n),
        .wbuf_valid, .wbuf_ready, .wbuf_data,
        .wrsp_valid, .wrsp_ready, .wrsp_resp,
        .rbuf_valid, .rbuf_ready, .rbuf_data,
        .rrsp_valid, .rrsp_ready, .rrsp_data, .rrsp_resp
    );

endmodule

`default_nettype wire

/* src/lite_reg_file.sv */
`default_nettype none

module lite_reg_file (
    input  logic                              clock,
    input  logic                              rst_n,

    input  logic                              wbuf_valid,
    output logic                              wbuf_ready,
    input  logic [axi_bridge_pkg::WREQ_W-1:0] wbuf_data,

    output logic                              wrsp_valid,
    input  logic                              wrsp_ready,
    output axi_bridge_pkg::resp_t             wrsp_resp,

    input  logic                              rbuf_valid,
    output logic                              rbuf_ready,
    input  logic [axi_bridge_pkg::RREQ_W-1:0] rbuf_data,

    output logic                              rrsp_valid,
    input  logic                              rrsp_ready,
    output axi_bridge_pkg::data_t             rrsp_data,
    output axi_bridge_pkg::resp_t             rrsp_resp
);

    axi_bridge_pkg::data_t    regs [axi_bridge_pkg::REG_COUNT];
    axi_bridge_pkg::addr_t    w_addr;
    axi_bridge_pkg::data_t    w_data;
    axi_bridge_pkg::strb_t    w_strb;
    axi_bridge_pkg::addr_t    r_addr;
    axi_bridge_pkg::reg_idx_t w_idx;
    axi_bridge_pkg::reg_idx_t r_idx;
    logic                     w_hit;
    logic                     r_hit;

    assign {w_addr, w_data, w_strb} = wbuf_data;
    assign r_addr = rbuf_data;
    assign w_idx  = w_addr[5:2];   // bits [1:0] are ignored.
    assign r_idx  = r_addr[5:2];
    assign w_hit  = (w_addr[31:6] == '0);
    assign r_hit  = (r_addr[31:6] == '0);

    // one response of each kind may be outstanding.
    assign wbuf_ready = !wrsp_valid;
    assign rbuf_ready = !rrsp_valid;

    // ######################################
    // write side
    // ######################################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < axi_bridge_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            wrsp_valid <= 1'b0;
        end else if (wbuf_valid && wbuf_ready) begin
            wrsp_valid <= 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (w_hit && w_strb[b]) begin
                    regs[w_idx][8*b +: 8] <= w_data[8*b +: 8];
                end
            end
        end else if (wrsp_ready) begin
            wrsp_valid <= 1'b0;
        end
    end

    // ######################################
    // read side
    // ######################################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rrsp_valid <= 1'b0;
        end else if (rbuf_valid && rbuf_ready) begin
            rrsp_valid <= 1'b1;
        end else if (rrsp_ready) begin
            rrsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wbuf_valid && wbuf_ready) begin
            wrsp_resp <= w_hit ? axi_bridge_pkg::RESP_OKAY : axi_bridge_pkg::RESP_SLVERR;
        end
        if (rbuf_valid && rbuf_ready) begin
            rrsp_data <= r_hit ? regs[r_idx] : '0;   // outside the window reads zero.
            rrsp_resp <= r_hit ? axi_bridge_pkg::RESP_OKAY : axi_bridge_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

/* src/lite_skid_buffer.sv */
`default_nettype none

module lite_skid_buffer #(
    parameter int WIDTH = 32
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] slot [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic [1:0]       count_next;
    logic             push;
    logic             pop;

    assign push       = in_valid && in_ready;
    assign pop        = out_valid && out_ready;
    assign count_next = count + {1'b0, push} - {1'b0, pop};
    assign out_valid  = (count != 2'd0);
    assign out_data   = slot[rd_ptr];

    // in_ready comes from a flop, so no ready path runs through the buffer.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            in_ready <= 1'b0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            count    <= count_next;
            in_ready <= (count_next < 2'd2);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            slot[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* src/reset_stretch.sv */
`default_nettype none

module reset_stretch (
    input  logic clock,
    input  logic rst_n,
    output logic periph_rst_n
);

    // wide enough to hold RESET_HOLD itself.
    logic [$clog2(axi_bridge_pkg::RESET_HOLD + 1)-1:0] hold_cnt;

    // the counter reloads for as long as rst_n is low, and the peripheral
    // reset is released on the edge after it has run down to zero.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hold_cnt     <= ($bits(hold_cnt))'(axi_bridge_pkg::RESET_HOLD);
            periph_rst_n <= 1'b0;
        end else begin
            periph_rst_n <= (hold_cnt == '0);
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_gp_axi_bridge.sv */
`default_nettype none

module tb_gp_axi_bridge;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam axi_bridge_pkg::burst_t BURST_INCR = 2'b01;

    logic clock;
    logic rst_n;
    axi_bridge_pkg::id_t    awid, bid, arid, rid;
    axi_bridge_pkg::addr_t  awaddr, araddr;
    axi_bridge_pkg::len_t   awlen, arlen;
    axi_bridge_pkg::burst_t awburst, arburst;
    axi_bridge_pkg::data_t  wdata, rdata;
    axi_bridge_pkg::strb_t  wstrb;
    axi_bridge_pkg::resp_t  bresp, rresp;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;

    axi_bridge_pkg::data_t model [axi_bridge_pkg::REG_COUNT];   // expected register contents.
    axi_bridge_pkg::data_t beat_data [16];
    axi_bridge_pkg::strb_t beat_strb [16];
    logic [31:0]           rng_state;
    logic                  random_ready;
    int                    cycle_count;

    gp_axi_bridge dut0 (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "simulation timed out");
        end
    end

    // ######################################
    // random numbers and reference model
    // ######################################

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // always ready unless back-pressure is switched on.
    function automatic logic ready_bit();
        logic [31:0] r;
        if (!random_ready) return 1'b1;
        r = next_random();
        return r[0];
    endfunction

    function automatic logic in_window(axi_bridge_pkg::addr_t a);
        return a[31:6] == '0;
    endfunction

    function automatic axi_bridge_pkg::addr_t beat_addr(axi_bridge_pkg::addr_t base,
                                                         axi_bridge_pkg::burst_t burst, int i);
        if (burst == axi_bridge_pkg::BURST_FIXED) return base;
        return base + 32'(4 * i);
    endfunction

    function automatic axi_bridge_pkg::resp_t model_write(axi_bridge_pkg::addr_t a,
                                                          axi_bridge_pkg::data_t d,
                                                          axi_bridge_pkg::strb_t s);
        if (!in_window(a)) return axi_bridge_pkg::RESP_SLVERR;   // nothing is written.
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                model[a[5:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
        return axi_bridge_pkg::RESP_OKAY;
    endfunction

    // ######################################
    // compare tasks
    // ######################################

    task automatic check_data(axi_bridge_pkg::data_t got, axi_bridge_pkg::data_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_resp(axi_bridge_pkg::resp_t got, axi_bridge_pkg::resp_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_id(axi_bridge_pkg::id_t got, axi_bridge_pkg::id_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "id mismatch");
        end
    endtask

    task automatic check_last(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "rlast mismatch");
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "handshake signal mismatch");
        end
    endtask

    // ######################################
    // bus tasks
    // ######################################

    // beats come from beat_data and beat_strb; every task starts just after a rising edge.
    task automatic axi_write_burst(axi_bridge_pkg::id_t id, axi_bridge_pkg::addr_t addr,
                                   axi_bridge_pkg::len_t len, axi_bridge_pkg::burst_t burst);
        axi_bridge_pkg::resp_t exp_resp;
        logic                  done;
        exp_resp = axi_bridge_pkg::RESP_OKAY;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awburst = burst;
        awvalid = 1'b1;
        @(negedge clock);
        while (!awready) @(negedge clock);
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            wdata  = beat_data[i];
            wstrb  = beat_strb[i];
            wlast  = (i == int'(len));
            wvalid = 1'b1;
            if (model_write(beat_addr(addr, burst, i), beat_data[i], beat_strb[i])
                    == axi_bridge_pkg::RESP_SLVERR) begin
                exp_resp = axi_bridge_pkg::RESP_SLVERR;   // one bad beat fails the burst.
            end
            @(negedge clock);
            while (!wready) @(negedge clock);
            @(posedge clock);
            #1;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        done   = 1'b0;
        while (!done) begin
            bready = ready_bit();
            @(negedge clock);
            if (bvalid && bready) begin
                check_id(bid, id, "bid");
                check_resp(bresp, exp_resp, "bresp");
                done = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        bready = 1'b0;
        @(negedge clock);
        check_flag(bvalid, 1'b0, "bvalid after the B handshake");
        @(posedge clock);
        #1;
    endtask

    task automatic axi_read_burst(axi_bridge_pkg::id_t id, axi_bridge_pkg::addr_t addr,
                                  axi_bridge_pkg::len_t len, axi_bridge_pkg::burst_t burst);
        int                    beat;
        axi_bridge_pkg::addr_t a;
        axi_bridge_pkg::data_t exp_data;
        axi_bridge_pkg::resp_t exp_resp;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arburst = burst;
        arvalid = 1'b1;
        @(negedge clock);
        while (!arready) @(negedge clock);
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        beat    = 0;
        while (beat <= int'(len)) begin
            rready = ready_bit();
            @(negedge clock);
            if (rvalid && rready) begin
                a        = beat_addr(addr, burst, beat);
                exp_data = in_window(a) ? model[a[5:2]] : '0;
                exp_resp = in_window(a) ? axi_bridge_pkg::RESP_OKAY : axi_bridge_pkg::RESP_SLVERR;
                check_id(rid, id, "rid");
                check_data(rdata, exp_data, "rdata");
                check_resp(rresp, exp_resp, "rresp");
                check_last(rlast, beat == int'(len), "rlast");
                beat++;
            end
            @(posedge clock);
            #1;
        end
        rready = 1'b0;
        @(negedge clock);
        check_flag(rvalid, 1'b0, "rvalid after the last beat");   // no extra beat.
        @(posedge clock);
        #1;
    endtask

    // ######################################
    // tests
    // ######################################

    task automatic test_reset();
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_flag(bvalid, 1'b0, "bvalid in reset");
        check_flag(rvalid, 1'b0, "rvalid in reset");
        check_flag(wready, 1'b0, "wready in reset");
        @(posedge clock);
        #1;
        rst_n = 1'b1;
        repeat (axi_bridge_pkg::RESET_HOLD) begin
            @(negedge clock);
            check_flag(awready, 1'b0, "awready while the reset is held");
            check_flag(arready, 1'b0, "arready while the reset is held");
            check_flag(wready, 1'b0, "wready while the reset is held");
            check_flag(bvalid, 1'b0, "bvalid after reset");
            check_flag(rvalid, 1'b0, "rvalid after reset");
        end
        while (!(awready && arready)) begin
            @(negedge clock);
            check_flag(wready, 1'b0, "wready after reset");
            check_flag(bvalid, 1'b0, "bvalid after reset");
            check_flag(rvalid, 1'b0, "rvalid after reset");
        end
        @(posedge clock);
        #1;
    endtask

    task automatic test_single_write();
        beat_data[0] = 32'h1122_3344;
        beat_strb[0] = 4'hF;
        axi_write_burst(12'h001, 32'h08, 4'd0, BURST_INCR);
        beat_data[0] = 32'hA1B2_C3D4;
        beat_strb[0] = 4'b0101;
        axi_write_burst(12'h002, 32'h08, 4'd0, BURST_INCR);
        axi_read_burst(12'h003, 32'h08, 4'd0, BURST_INCR);
    endtask

    task automatic test_incr_burst();
        for (int i = 0; i < 16; i++) begin
            beat_data[i] = next_random();
            beat_strb[i] = 4'hF;
        end
        axi_write_burst(12'h5A3, 32'h00, 4'd15, BURST_INCR);
        axi_read_burst(12'h3C5, 32'h00, 4'd15, BURST_INCR);
    endtask

    task automatic test_fixed_burst();
        for (int i = 0; i < 4; i++) begin
            beat_data[i] = next_random();
            beat_strb[i] = 4'hF;
        end
        axi_write_burst(12'h101, 32'h14, 4'd3, axi_bridge_pkg::BURST_FIXED);
        axi_read_burst(12'h102, 32'h14, 4'd3, axi_bridge_pkg::BURST_FIXED);
    endtask

    // the last two beats land at 0x40 and 0x44, past the register window.
    task automatic test_out_of_window();
        for (int i = 0; i < 4; i++) begin
            beat_data[i] = next_random();
            beat_strb[i] = 4'hF;
        end
        axi_write_burst(12'h7FF, 32'h38, 4'd3, BURST_INCR);
        axi_read_burst(12'h7FE, 32'h38, 4'd3, BURST_INCR);
        axi_read_burst(12'h7FD, 32'h00, 4'd15, BURST_INCR);
    endtask

    task automatic test_back_pressure();
        logic [31:0]            r;
        axi_bridge_pkg::addr_t  addr;
        axi_bridge_pkg::burst_t burst;
        random_ready = 1'b1;
        repeat (6) begin
            r     = next_random();
            addr  = {26'd0, r[9:6], 2'b00};
            burst = r[4] ? BURST_INCR : axi_bridge_pkg::BURST_FIXED;
            for (int i = 0; i < 16; i++) begin
                beat_data[i] = next_random();
                beat_strb[i] = axi_bridge_pkg::strb_t'(next_random());
            end
            axi_write_burst(r[21:10], addr, r[3:0], burst);
            axi_read_burst(r[31:20], addr, r[3:0], burst);
        end
        random_ready = 1'b0;
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        cycle_count  = 0;
        rng_state    = 32'd14975;
        random_ready = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < axi_bridge_pkg::REG_COUNT; i++) begin
            model[i] = '0;   // registers come out of reset as zero.
        end

        test_reset();
        test_single_write();
        test_incr_burst();
        test_fixed_burst();
        test_out_of_window();
        test_back_pressure();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
